// File: verilog/shim_settings.svh
`ifndef SHIM_SETTINGS_SVH
`define SHIM_SETTINGS_SVH

// Request header carries address and tag
`define SHIM_REQ_HDR_WIDTH 32

// Response tag and payload widths
`define SHIM_RSP_HDR_WIDTH 16
`define SHIM_RSP_DATA_WIDTH 32

// Request FIFO depth as a power of two (16 entries)
`define SHIM_REQ_DEPTH_RADIX 4

// Response FIFO depth as a power of two (32 entries)
`define SHIM_RSP_DEPTH_RADIX 5

// Response slots held back for requests still in flight after almost-full
`define SHIM_ALMFULL_SLACK 16

`endif

// File: verilog/shim_pkg.sv
`default_nettype none

`include "shim_settings.svh"

package shim_pkg;

    // Request header as seen on both sides of the shim
    typedef logic [`SHIM_REQ_HDR_WIDTH-1:0] t_req_hdr;

    // Response tag, returned with each read response
    typedef logic [`SHIM_RSP_HDR_WIDTH-1:0] t_rsp_hdr;

    // Response payload
    typedef logic [`SHIM_RSP_DATA_WIDTH-1:0] t_rsp_data;

    // Outstanding request count
    // One bit wider than the response FIFO radix so a full FIFO's worth fits
    typedef logic [`SHIM_RSP_DEPTH_RADIX:0] t_credit_cnt;

endpackage

`default_nettype wire

// File: verilog/dc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module dc_fifo
#(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH_RADIX = 4
)
(
    input  logic                   wr_clk,
    input  logic                   wr_reset,
    input  logic                   wr_en,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    input  logic                   rd_clk,
    input  logic                   rd_reset,
    input  logic                   rd_en,
    output logic                   wr_full,
    output logic [DEPTH_RADIX-1:0] wr_used,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   rd_empty
);

    localparam int DEPTH = 1 << DEPTH_RADIX;

    // Storage, indexed by the low pointer bits
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [DEPTH_RADIX:0] wr_bin;
    logic [DEPTH_RADIX:0] wr_bin_next;
    logic [DEPTH_RADIX:0] wr_gray;
    logic [DEPTH_RADIX:0] rd_bin;
    logic [DEPTH_RADIX:0] rd_bin_next;
    logic [DEPTH_RADIX:0] rd_gray;

    // Read pointer as seen from the write clock
    logic [DEPTH_RADIX:0] rd_gray_meta;
    logic [DEPTH_RADIX:0] rd_gray_sync;
    logic [DEPTH_RADIX:0] rd_bin_in_wr;

    // Write pointer as seen from the read clock
    logic [DEPTH_RADIX:0] wr_gray_meta;
    logic [DEPTH_RADIX:0] wr_gray_sync;

    logic [DEPTH_RADIX:0] fill;
    logic                 wr_accept;
    logic                 rd_accept;

    function automatic logic [DEPTH_RADIX:0] bin2gray(input logic [DEPTH_RADIX:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [DEPTH_RADIX:0] gray2bin(input logic [DEPTH_RADIX:0] g);
        logic [DEPTH_RADIX:0] b;
        b[DEPTH_RADIX] = g[DEPTH_RADIX];
        for (int i = DEPTH_RADIX - 1; i >= 0; i--)
        begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Writes that meet a full FIFO are dropped
    assign wr_accept = wr_en && !wr_full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk)
    begin
        if (wr_accept)
        begin
            mem[wr_bin[DEPTH_RADIX-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk)
    begin
        if (wr_reset)
        begin
            wr_bin <= '0;
            wr_gray <= '0;
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end
        else
        begin
            if (wr_accept)
            begin
                wr_bin <= wr_bin_next;
                wr_gray <= bin2gray(wr_bin_next);
            end
            // Two-flop synchronizer on the Gray read pointer
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    // Fill level is pessimistic by the synchronizer delay
    assign rd_bin_in_wr = gray2bin(rd_gray_sync);
    assign fill = wr_bin - rd_bin_in_wr;
    // Top fill bit is only set at exactly DEPTH entries
    assign wr_full = fill[DEPTH_RADIX];
    // Saturate so a full FIFO still reports its top used bit
    assign wr_used = wr_full ? '1 : fill[DEPTH_RADIX-1:0];

    // Empty when the read pointer caught up with the synced write pointer
    assign rd_empty = (rd_gray == wr_gray_sync);
    assign rd_accept = rd_en && !rd_empty;
    assign rd_bin_next = rd_bin + 1'b1;

    always_ff @(posedge rd_clk)
    begin
        if (rd_reset)
        begin
            rd_bin <= '0;
            rd_gray <= '0;
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end
        else
        begin
            if (rd_accept)
            begin
                rd_bin <= rd_bin_next;
                rd_gray <= bin2gray(rd_bin_next);
            end
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    // Data shows up on the clock after the read strobe
    always_ff @(posedge rd_clk)
    begin
        if (rd_accept)
        begin
            rd_data <= mem[rd_bin[DEPTH_RADIX-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: verilog/req_path.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_settings.svh"

module req_path
    import shim_pkg::*;
(
    input  logic        afu_clk,
    input  logic        afu_softreset,
    input  logic        bb_clk,
    input  logic        bb_reset,
    input  logic        req_valid,
    input  t_req_hdr    req_hdr,
    input  logic        bb_almost_full,
    input  t_credit_cnt credit_cnt,
    output logic        afu_almost_full,
    output logic        bb_req_valid,
    output t_req_hdr    bb_req_hdr,
    output logic        req_overflow
);

    localparam int REQ_RADIX = `SHIM_REQ_DEPTH_RADIX;

    // Responses the accelerator may have outstanding before it is throttled
    localparam int CREDIT_LIMIT = (1 << `SHIM_RSP_DEPTH_RADIX) - `SHIM_ALMFULL_SLACK;

    logic [REQ_RADIX-1:0] fifo_used;
    logic                 fifo_full;
    logic                 fifo_empty;
    logic                 fifo_rd;

    // Response FIFO must leave room beyond the slack
    if (CREDIT_LIMIT <= 0)
    begin : g_credit_limit_check
        $error("SHIM_RSP_DEPTH_RADIX too small for SHIM_ALMFULL_SLACK");
    end

    dc_fifo
    #(
        .DATA_WIDTH  ($bits(t_req_hdr)),
        .DEPTH_RADIX (REQ_RADIX)
    )
    i_req_fifo
    (
        .wr_clk   (afu_clk),
        .wr_reset (afu_softreset),
        .wr_en    (req_valid),
        .wr_data  (req_hdr),
        .rd_clk   (bb_clk),
        .rd_reset (bb_reset),
        .rd_en    (fifo_rd),
        .wr_full  (fifo_full),
        .wr_used  (fifo_used),
        .rd_data  (bb_req_hdr),
        .rd_empty (fifo_empty)
    );

    // Drain toward the platform while it has room
    assign fifo_rd = !fifo_empty && !bb_almost_full;

    // Valid lines up with the FIFO read data
    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            bb_req_valid <= 1'b0;
        end
        else
        begin
            bb_req_valid <= fifo_rd;
        end
    end

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            afu_almost_full <= 1'b0;
            req_overflow <= 1'b0;
        end
        else
        begin
            // Half full or too many responses owed
            afu_almost_full <= fifo_used[REQ_RADIX-1] ||
                               (credit_cnt > t_credit_cnt'(CREDIT_LIMIT));
            // Sticky once a request is dropped
            req_overflow <= req_overflow || (req_valid && fifo_full);
        end
    end

endmodule

`default_nettype wire

// File: verilog/rsp_path.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_settings.svh"

module rsp_path
    import shim_pkg::*;
(
    input  logic      afu_clk,
    input  logic      afu_softreset,
    input  logic      bb_clk,
    input  logic      bb_reset,
    input  logic      bb_rsp_valid,
    input  t_rsp_hdr  bb_rsp_hdr,
    input  t_rsp_data bb_rsp_data,
    output logic      afu_rsp_valid,
    output t_rsp_hdr  afu_rsp_hdr,
    output t_rsp_data afu_rsp_data,
    output logic      rsp_overflow
);

    localparam int RSP_WIDTH = $bits(t_rsp_hdr) + $bits(t_rsp_data);

    logic                 fifo_full;
    logic                 fifo_empty;
    logic                 fifo_rd;

    // Tag and data share one FIFO word
    dc_fifo
    #(
        .DATA_WIDTH  (RSP_WIDTH),
        .DEPTH_RADIX (`SHIM_RSP_DEPTH_RADIX)
    )
    i_rsp_fifo
    (
        .wr_clk   (bb_clk),
        .wr_reset (bb_reset),
        .wr_en    (bb_rsp_valid),
        .wr_data  ({bb_rsp_hdr, bb_rsp_data}),
        .rd_clk   (afu_clk),
        .rd_reset (afu_softreset),
        .rd_en    (fifo_rd),
        .wr_full  (fifo_full),
        .wr_used  (),
        .rd_data  ({afu_rsp_hdr, afu_rsp_data}),
        .rd_empty (fifo_empty)
    );

    // No back-pressure toward the accelerator
    assign fifo_rd = !fifo_empty;

    // One-cycle strobe per delivered response
    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            afu_rsp_valid <= 1'b0;
        end
        else
        begin
            afu_rsp_valid <= fifo_rd;
        end
    end

    // Platform cannot be stalled, so a full FIFO loses the response
    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            rsp_overflow <= 1'b0;
        end
        else
        begin
            rsp_overflow <= rsp_overflow || (bb_rsp_valid && fifo_full);
        end
    end

endmodule

`default_nettype wire

// File: verilog/credit_tracker.sv
`timescale 1ns/1ns
`default_nettype none

`include "shim_settings.svh"

module credit_tracker
    import shim_pkg::*;
(
    input  logic        afu_clk,
    input  logic        afu_softreset,
    input  logic        req_valid,
    input  logic        rsp_valid,
    output t_credit_cnt credit_cnt
);

    // Count never needs to exceed the response FIFO depth
    localparam int MAX_CNT = 1 << `SHIM_RSP_DEPTH_RADIX;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            credit_cnt <= '0;
        end
        else if (req_valid && !rsp_valid)
        begin
            // New request, one more response owed
            if (credit_cnt != t_credit_cnt'(MAX_CNT))
            begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
        else if (rsp_valid && !req_valid)
        begin
            // Response handed back, guard against underflow
            if (credit_cnt != '0)
            begin
                credit_cnt <= credit_cnt - 1'b1;
            end
        end
        // Both or neither leaves the count alone
    end

endmodule

`default_nettype wire

// File: verilog/ccip_async_shim.sv
`timescale 1ns/1ns
`default_nettype none

module ccip_async_shim
    import shim_pkg::*;
(
    input  logic       afu_clk,
    input  logic       bb_clk,
    input  logic       afu_softreset,
    input  logic       afu_req_valid,
    input  t_req_hdr   afu_req_hdr,
    input  logic       bb_almost_full,
    input  logic       bb_rsp_valid,
    input  t_rsp_hdr   bb_rsp_hdr,
    input  t_rsp_data  bb_rsp_data,
    output logic       afu_almost_full,
    output logic       afu_rsp_valid,
    output t_rsp_hdr   afu_rsp_hdr,
    output t_rsp_data  afu_rsp_data,
    output logic       bb_req_valid,
    output t_req_hdr   bb_req_hdr,
    output logic [1:0] shim_error
);

    // Reset carried into the platform clock
    logic [2:0]  bb_reset_sync;
    logic        bb_reset;

    // Accelerator inputs, afu_clk
    logic        req_valid_q;
    t_req_hdr    req_hdr_q;

    // Platform inputs, bb_clk
    logic        bb_almost_full_q;
    logic        bb_rsp_valid_q;
    t_rsp_hdr    bb_rsp_hdr_q;
    t_rsp_data   bb_rsp_data_q;

    t_credit_cnt credit_cnt;
    logic        req_overflow;
    logic        rsp_overflow;

    // Three flops, release lags afu_softreset by three bb_clk edges
    always_ff @(posedge bb_clk)
    begin
        bb_reset_sync <= {bb_reset_sync[1:0], afu_softreset};
    end

    assign bb_reset = bb_reset_sync[2];

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            req_valid_q <= 1'b0;
        end
        else
        begin
            req_valid_q <= afu_req_valid;
        end
        req_hdr_q <= afu_req_hdr;
    end

    always_ff @(posedge bb_clk)
    begin
        if (bb_reset)
        begin
            bb_almost_full_q <= 1'b0;
            bb_rsp_valid_q <= 1'b0;
        end
        else
        begin
            bb_almost_full_q <= bb_almost_full;
            bb_rsp_valid_q <= bb_rsp_valid;
        end
        bb_rsp_hdr_q <= bb_rsp_hdr;
        bb_rsp_data_q <= bb_rsp_data;
    end

    // Outputs leave straight from the flops inside the paths
    req_path i_req_path
    (
        .afu_clk         (afu_clk),
        .afu_softreset   (afu_softreset),
        .bb_clk          (bb_clk),
        .bb_reset        (bb_reset),
        .req_valid       (req_valid_q),
        .req_hdr         (req_hdr_q),
        .bb_almost_full  (bb_almost_full_q),
        .credit_cnt      (credit_cnt),
        .afu_almost_full (afu_almost_full),
        .bb_req_valid    (bb_req_valid),
        .bb_req_hdr      (bb_req_hdr),
        .req_overflow    (req_overflow)
    );

    rsp_path i_rsp_path
    (
        .afu_clk       (afu_clk),
        .afu_softreset (afu_softreset),
        .bb_clk        (bb_clk),
        .bb_reset      (bb_reset),
        .bb_rsp_valid  (bb_rsp_valid_q),
        .bb_rsp_hdr    (bb_rsp_hdr_q),
        .bb_rsp_data   (bb_rsp_data_q),
        .afu_rsp_valid (afu_rsp_valid),
        .afu_rsp_hdr   (afu_rsp_hdr),
        .afu_rsp_data  (afu_rsp_data),
        .rsp_overflow  (rsp_overflow)
    );

    // Requests in, delivered responses out
    credit_tracker i_credit_tracker
    (
        .afu_clk       (afu_clk),
        .afu_softreset (afu_softreset),
        .req_valid     (req_valid_q),
        .rsp_valid     (afu_rsp_valid),
        .credit_cnt    (credit_cnt)
    );

    // Bit 0 request drop (afu_clk), bit 1 response drop (bb_clk)
    assign shim_error = {rsp_overflow, req_overflow};

endmodule

`default_nettype wire

// File: dv/shim_checker.sv
`timescale 1ns/1ns
`default_nettype none

module shim_checker
(
    input logic       afu_clk,
    input logic       bb_clk,
    input logic       afu_softreset,
    input logic       bb_reset,
    input logic       req_valid,
    input logic       afu_almost_full,
    input logic       afu_rsp_valid,
    input logic       bb_req_valid,
    input logic [1:0] shim_error
);

    // Set by the first registered request after reset
    logic seen_req;

    always_ff @(posedge afu_clk)
    begin
        if (afu_softreset)
        begin
            seen_req <= 1'b0;
        end
        else if (req_valid)
        begin
            seen_req <= 1'b1;
        end
    end

    // Error bits are sticky, each in its own clock domain
    a_req_err_sticky: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        !$fell(shim_error[0])) else $error("shim_error[0] cleared without reset");

    a_rsp_err_sticky: assert property (@(posedge bb_clk) disable iff (bb_reset)
        !$fell(shim_error[1])) else $error("shim_error[1] cleared without reset");

    // Strobes stay quiet while their domain is in reset
    a_rsp_valid_reset: assert property (@(posedge afu_clk)
        afu_softreset |=> !afu_rsp_valid) else $error("afu_rsp_valid high in reset");

    a_req_valid_reset: assert property (@(posedge bb_clk)
        bb_reset |=> !bb_req_valid) else $error("bb_req_valid high in reset");

    // Nothing queued and nothing owed, so no throttling
    a_almfull_idle: assert property (@(posedge afu_clk) disable iff (afu_softreset)
        !seen_req |-> !afu_almost_full) else $error("afu_almost_full before any request");

endmodule

`default_nettype wire

// File: dv/shim_tb.sv
`timescale 1ns/1ns
`include "shim_settings.svh"
`default_nettype none

module shim_tb
    import shim_pkg::*;
();

    // Six tests with resets and drains need a few hundred cycles, so this leaves wide margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int REQ_DEPTH = 1 << `SHIM_REQ_DEPTH_RADIX;
    localparam int CREDIT_LIMIT = (1 << `SHIM_RSP_DEPTH_RADIX) - `SHIM_ALMFULL_SLACK;
    localparam logic [31:0] SEED = 32'hb848;

    logic       afu_clk = 1'b0;
    logic       bb_clk = 1'b0;
    logic       afu_softreset;
    logic       afu_req_valid;
    t_req_hdr   afu_req_hdr;
    logic       bb_almost_full;
    logic       bb_rsp_valid;
    t_rsp_hdr   bb_rsp_hdr;
    t_rsp_data  bb_rsp_data;
    logic       afu_almost_full;
    logic       afu_rsp_valid;
    t_rsp_hdr   afu_rsp_hdr;
    t_rsp_data  afu_rsp_data;
    logic       bb_req_valid;
    t_req_hdr   bb_req_hdr;
    logic [1:0] shim_error;

    // Issued headers, headers seen by the platform, and those still unanswered
    t_req_hdr   sent_q[$];
    t_req_hdr   seen_q[$];
    t_req_hdr   pend_q[$];
    t_rsp_hdr   rsp_hdr_q[$];
    t_rsp_data  rsp_data_q[$];
    t_req_hdr   rsp_src;
    bit         answer_en;
    int         errors;
    int         checks;
    int         tests;
    int         cycle_cnt;

    always #10 afu_clk = ~afu_clk;
    // Platform clock with its own 12 ns period
    always #6 bb_clk = ~bb_clk;

    ccip_async_shim i_ccip_async_shim
    (
        .afu_clk         (afu_clk),
        .bb_clk          (bb_clk),
        .afu_softreset   (afu_softreset),
        .afu_req_valid   (afu_req_valid),
        .afu_req_hdr     (afu_req_hdr),
        .bb_almost_full  (bb_almost_full),
        .bb_rsp_valid    (bb_rsp_valid),
        .bb_rsp_hdr      (bb_rsp_hdr),
        .bb_rsp_data     (bb_rsp_data),
        .afu_almost_full (afu_almost_full),
        .afu_rsp_valid   (afu_rsp_valid),
        .afu_rsp_hdr     (afu_rsp_hdr),
        .afu_rsp_data    (afu_rsp_data),
        .bb_req_valid    (bb_req_valid),
        .bb_req_hdr      (bb_req_hdr),
        .shim_error      (shim_error)
    );

    bind ccip_async_shim shim_checker i_shim_checker
    (
        .afu_clk         (afu_clk),
        .bb_clk          (bb_clk),
        .afu_softreset   (afu_softreset),
        .bb_reset        (bb_reset),
        .req_valid       (req_valid_q),
        .afu_almost_full (afu_almost_full),
        .afu_rsp_valid   (afu_rsp_valid),
        .bb_req_valid    (bb_req_valid),
        .shim_error      (shim_error)
    );

    // Platform model records every request leaving the shim
    always @(posedge bb_clk)
    begin
        if (bb_req_valid === 1'b1)
        begin
            seen_q.push_back(bb_req_hdr);
            pend_q.push_back(bb_req_hdr);
        end
    end

    // Answers one pending request per bb_clk when enabled
    // Tag is the low header bits and data the inverted header
    always @(posedge bb_clk)
    begin
        #2;
        if (answer_en && pend_q.size() != 0)
        begin
            rsp_src = pend_q.pop_front();
            bb_rsp_valid = 1'b1;
            bb_rsp_hdr = rsp_src[15:0];
            bb_rsp_data = ~rsp_src;
        end
        else
        begin
            bb_rsp_valid = 1'b0;
        end
    end

    // Accelerator side response capture
    always @(posedge afu_clk)
    begin
        if (afu_rsp_valid === 1'b1)
        begin
            rsp_hdr_q.push_back(afu_rsp_hdr);
            rsp_data_q.push_back(afu_rsp_data);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("Test %0d %s done, %0d errors", tests, name, errors - errs_before);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge afu_clk);
        end
        #2;
    endtask

    task automatic set_bb_almost_full(input logic level);
        @(posedge bb_clk);
        #2;
        bb_almost_full = level;
        idle_cycles(1);
    endtask

    // Holds reset for 8 cycles, then lets the bb side reset release and clears the models
    task automatic apply_reset();
        answer_en = 1'b0;
        afu_req_valid = 1'b0;
        set_bb_almost_full(1'b0);
        afu_softreset = 1'b1;
        idle_cycles(8);
        afu_softreset = 1'b0;
        idle_cycles(4);
        sent_q.delete();
        seen_q.delete();
        pend_q.delete();
        rsp_hdr_q.delete();
        rsp_data_q.delete();
    endtask

    // Random headers with an optional pause while almost-full is high
    task automatic issue_burst(input int n, input bit obey);
        t_req_hdr hdr;
        for (int i = 0; i < n; i++)
        begin
            while (obey && afu_almost_full === 1'b1)
            begin
                idle_cycles(1);
            end
            hdr = $urandom();
            sent_q.push_back(hdr);
            afu_req_valid = 1'b1;
            afu_req_hdr = hdr;
            idle_cycles(1);
            afu_req_valid = 1'b0;
        end
    endtask

    task automatic wait_seen(input int n, input int limit);
        int cnt;
        cnt = 0;
        while (seen_q.size() < n && cnt < limit)
        begin
            idle_cycles(1);
            cnt++;
        end
        check_value("bb_req_valid count", seen_q.size(), n);
    endtask

    task automatic wait_responses(input int n, input int limit);
        int cnt;
        cnt = 0;
        while (rsp_hdr_q.size() < n && cnt < limit)
        begin
            idle_cycles(1);
            cnt++;
        end
        check_value("afu_rsp_valid count", rsp_hdr_q.size(), n);
    endtask

    task automatic wait_almost_full(input logic level, input int limit);
        int cnt;
        cnt = 0;
        while (afu_almost_full !== level && cnt < limit)
        begin
            idle_cycles(1);
            cnt++;
        end
        check_value("afu_almost_full", afu_almost_full, level);
    endtask

    task automatic compare_requests(input int n);
        for (int i = 0; i < n && i < seen_q.size(); i++)
        begin
            check_value("bb_req_hdr", seen_q[i], sent_q[i]);
        end
    endtask

    task automatic compare_responses(input int n);
        for (int i = 0; i < n && i < rsp_hdr_q.size(); i++)
        begin
            check_value("afu_rsp_hdr", rsp_hdr_q[i], sent_q[i][15:0]);
            check_value("afu_rsp_data", rsp_data_q[i], t_rsp_data'(~sent_q[i]));
        end
    endtask

    task automatic reset_state();
        int errs_before;
        errs_before = errors;
        apply_reset();
        check_value("bb_req_valid", bb_req_valid, 1'b0);
        check_value("afu_rsp_valid", afu_rsp_valid, 1'b0);
        check_value("afu_almost_full", afu_almost_full, 1'b0);
        check_value("shim_error", shim_error, 2'b00);
        report_test("reset state", errs_before);
    endtask

    task automatic request_ordering();
        int errs_before;
        errs_before = errors;
        apply_reset();
        issue_burst(10, 1'b0);
        wait_seen(10, 100);
        compare_requests(10);
        report_test("request ordering", errs_before);
    endtask

    task automatic response_ordering();
        int errs_before;
        errs_before = errors;
        apply_reset();
        answer_en = 1'b1;
        issue_burst(10, 1'b0);
        wait_responses(10, 200);
        compare_responses(10);
        check_value("shim_error", shim_error, 2'b00);
        report_test("response ordering", errs_before);
    endtask

    task automatic back_pressure();
        int errs_before;
        errs_before = errors;
        apply_reset();
        set_bb_almost_full(1'b1);
        // Three quarters of the request FIFO fills it past the half-full mark
        issue_burst(REQ_DEPTH * 3 / 4, 1'b0);
        wait_almost_full(1'b1, 40);
        idle_cycles(20);
        check_value("bb_req_valid count while held <= 2", seen_q.size() <= 2, 1'b1);
        set_bb_almost_full(1'b0);
        wait_seen(REQ_DEPTH * 3 / 4, 100);
        compare_requests(REQ_DEPTH * 3 / 4);
        wait_almost_full(1'b0, 100);
        report_test("back-pressure", errs_before);
    endtask

    task automatic credit_limit();
        int errs_before;
        errs_before = errors;
        apply_reset();
        // One request beyond the credit limit with none answered yet
        issue_burst(CREDIT_LIMIT + 1, 1'b1);
        wait_seen(CREDIT_LIMIT + 1, 100);
        wait_almost_full(1'b1, 20);
        answer_en = 1'b1;
        wait_responses(CREDIT_LIMIT + 1, 200);
        compare_responses(CREDIT_LIMIT + 1);
        wait_almost_full(1'b0, 40);
        check_value("shim_error", shim_error, 2'b00);
        report_test("credit limit", errs_before);
    endtask

    task automatic overflow_sticky();
        int errs_before;
        errs_before = errors;
        apply_reset();
        set_bb_almost_full(1'b1);
        issue_burst(REQ_DEPTH + 4, 1'b0);
        idle_cycles(4);
        check_value("shim_error[0]", shim_error[0], 1'b1);
        // Only the first FIFO's worth survives
        set_bb_almost_full(1'b0);
        wait_seen(REQ_DEPTH, 100);
        compare_requests(REQ_DEPTH);
        idle_cycles(20);
        check_value("shim_error[0]", shim_error[0], 1'b1);
        check_value("shim_error[1]", shim_error[1], 1'b0);
        apply_reset();
        check_value("shim_error", shim_error, 2'b00);
        report_test("overflow", errs_before);
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES)
        begin
            @(posedge afu_clk);
            cycle_cnt++;
        end
        $display("Run stopped, no result after %0d afu_clk cycles", cycle_cnt);
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        afu_softreset = 1'b1;
        afu_req_valid = 1'b0;
        afu_req_hdr = '0;
        bb_almost_full = 1'b0;
        bb_rsp_valid = 1'b0;
        bb_rsp_hdr = '0;
        bb_rsp_data = '0;
        answer_en = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        void'($urandom(SEED));
        reset_state();
        request_ordering();
        response_ordering();
        back_pressure();
        credit_limit();
        overflow_sticky();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/shim_pkg.sv
verilog/dc_fifo.sv
verilog/req_path.sv
verilog/rsp_path.sv
verilog/credit_tracker.sv
verilog/ccip_async_shim.sv
dv/shim_checker.sv
dv/shim_tb.sv

// File: Makefile
# Verilator flow for the async shim testbench
# Override any variable on the command line, e.g. make sim SIM_LOG=run.log

VERILATOR  ?= verilator
TOP        ?= shim_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
SIM_LOG    ?= sim.log
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= --timing -Wall
PASS_TEXT  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Result is taken from the log, not from the exit code of the model
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -q "$(PASS_TEXT)" $(SIM_LOG) || \
		(echo "Simulation did not pass, see $(SIM_LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
